//--- lsu_params.svh
// width macros shared by the lsu rtl and its testbench, pulled in with `include

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////
// data bus
////////////////////

// data and address width of the core side and the memory bus
`define LSU_DATA_W 32

// one enable per byte lane
`define LSU_BE_W 4

// byte offset inside a word, low address bits
`define LSU_OFF_W 2

// step from the first to the second part of a split access
`define LSU_WORD_BYTES 4

`endif

//--- lsu_pkg.sv
// shared types of the load store unit, referenced by scoped name from every block

package lsu_pkg;

  ////////////////////
  // access size
  ////////////////////

  // encoding follows the execute stage, 2'b11 is never driven
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } data_type_e;

  ////////////////////
  // access fsm
  ////////////////////

  typedef enum logic [2:0] {
    IDLE,             // no access in progress
    WAIT_GNT_MIS,     // first part of a split waits for grant
    WAIT_RVALID_MIS,  // first part of a split in flight
    WAIT_GNT,         // aligned access or second part waits for grant
    WAIT_RVALID       // last part in flight
  } ls_state_e;

endpackage

//--- lsu_req_gen.sv
// request side of the lsu, builds bus address, byte enables and store data per part

`include "lsu_params.svh"

module lsu_req_gen (
  input  logic                   req_i,          // access pending from execute
  input  lsu_pkg::data_type_e    type_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,         // first address of the access
  input  logic [`LSU_DATA_W-1:0] wdata_i,        // store data, low aligned
  input  logic                   second_part_i,  // second part of a split on the bus
  output logic                   misaligned_o,   // first part of a split access
  output logic [`LSU_DATA_W-1:0] addr_o,
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o
);

  localparam logic [`LSU_BE_W-1:0] BE_ALL  = '1;
  localparam logic [`LSU_BE_W-1:0] BE_HALF = `LSU_BE_W'(2'b11);
  localparam logic [`LSU_BE_W-1:0] BE_ONE  = `LSU_BE_W'(1'b1);

  logic [`LSU_OFF_W-1:0]     offset;     // byte lane of the first byte
  logic [2*`LSU_DATA_W-1:0]  wdata_dbl;  // doubled word for the rotation

  assign offset = addr_i[`LSU_OFF_W-1:0];

  // word off the boundary, or a half whose upper byte lands in the next word
  always_comb begin
    misaligned_o = 1'b0;
    if (req_i && !second_part_i) begin
      unique case (type_i)
        lsu_pkg::WORD: misaligned_o = (offset != '0);
        lsu_pkg::HALF: misaligned_o = (offset == '1);
        default:       misaligned_o = 1'b0;  // bytes never cross
      endcase
    end
  end

  // second part goes to the next word, low bits unchanged
  assign addr_o = second_part_i ? addr_i + `LSU_DATA_W'(`LSU_WORD_BYTES) : addr_i;

  ////////////////////
  // byte enables
  ////////////////////

  // first part starts at the offset, second part takes the lanes left over
  always_comb begin
    unique case (type_i)
      lsu_pkg::WORD: begin
        if (!second_part_i) be_o = BE_ALL << offset;     // 1111 1110 1100 1000
        else                be_o = ~(BE_ALL << offset);  // 0001 0011 0111
      end
      lsu_pkg::HALF: begin
        if (!second_part_i) be_o = BE_HALF << offset;    // offset 3 keeps only lane 3
        else                be_o = BE_ONE;               // upper byte in lane 0
      end
      default:              be_o = BE_ONE << offset;     // byte
    endcase
  end

  // rotate store data up by the offset, both parts use the same rotation
  assign wdata_dbl = {wdata_i, wdata_i} << {offset, 3'b000};
  assign wdata_o   = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

//--- lsu_fsm.sv
// access fsm of the lsu, sequences one or two bus accesses per request from execute

module lsu_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,          // access pending from execute
  input  logic misaligned_i,   // access needs two parts
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  output logic split_o,        // first grant of a split until its last rvalid
  output logic second_part_o,  // second part requested or in flight
  output logic first_gnt_o,    // grant that opens an access
  output logic valid_o,        // access done, load data valid
  output logic busy_o
);

  lsu_pkg::ls_state_e state_q, state_d;
  logic               split_q, split_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d     = state_q;
    split_d     = split_q;
    data_req_o  = 1'b0;
    first_gnt_o = 1'b0;
    valid_o     = 1'b0;

    unique case (state_q)
      lsu_pkg::IDLE: begin
        if (req_i) begin
          data_req_o = 1'b1;
          if (data_gnt_i) begin
            first_gnt_o = 1'b1;
            split_d     = misaligned_i;
            state_d     = misaligned_i ? lsu_pkg::WAIT_RVALID_MIS : lsu_pkg::WAIT_RVALID;
          end else begin
            state_d     = misaligned_i ? lsu_pkg::WAIT_GNT_MIS : lsu_pkg::WAIT_GNT;
          end
        end
      end

      lsu_pkg::WAIT_GNT_MIS: begin
        data_req_o = 1'b1;  // held until granted
        if (data_gnt_i) begin
          first_gnt_o = 1'b1;
          split_d     = 1'b1;
          state_d     = lsu_pkg::WAIT_RVALID_MIS;
        end
      end

      // first part in flight, nothing else on the bus
      lsu_pkg::WAIT_RVALID_MIS: begin
        if (data_rvalid_i) begin
          state_d = lsu_pkg::WAIT_GNT;  // second part is requested next cycle
        end
      end

      // shared by aligned accesses and the second part of a split
      lsu_pkg::WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          first_gnt_o = !split_q;  // second part grant does not open an access
          state_d     = lsu_pkg::WAIT_RVALID;
        end
      end

      lsu_pkg::WAIT_RVALID: begin
        if (data_rvalid_i) begin
          valid_o = 1'b1;  // last rvalid closes the access
          split_d = 1'b0;
          state_d = lsu_pkg::IDLE;
        end
      end

      default: begin
        state_d = lsu_pkg::IDLE;  // unused encodings recover
        split_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lsu_pkg::IDLE;
      split_q <= 1'b0;
    end else begin
      state_q <= state_d;
      split_q <= split_d;
    end
  end

  ////////////////////
  // status levels
  ////////////////////

  assign split_o = split_q;

  // after the first rvalid of a split the fsm only visits WAIT_GNT and WAIT_RVALID
  assign second_part_o = split_q &&
                         ((state_q == lsu_pkg::WAIT_GNT) || (state_q == lsu_pkg::WAIT_RVALID));

  assign busy_o = data_req_o ||
                  (state_q == lsu_pkg::WAIT_RVALID) ||
                  (state_q == lsu_pkg::WAIT_RVALID_MIS);

endmodule

//--- lsu_load_align.sv
// response side of the lsu, aligns and extends load data and splits bus errors

`include "lsu_params.svh"

module lsu_load_align (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   first_gnt_i,    // attributes sampled here
  input  logic                   we_i,
  input  lsu_pkg::data_type_e    type_i,
  input  logic                   sign_ext_i,
  input  logic [`LSU_OFF_W-1:0]  offset_i,
  input  logic                   split_i,
  input  logic                   second_part_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   load_err_o,
  output logic                   store_err_o
);

  lsu_pkg::data_type_e      type_q;
  logic                     sign_ext_q;
  logic                     we_q;
  logic [`LSU_OFF_W-1:0]    offset_q;
  logic [`LSU_DATA_W-1:0]   rdata_q;        // raw first word, or last load result

  logic [2*`LSU_DATA_W-1:0] joined;         // current word above the saved one
  logic [`LSU_DATA_W-1:0]   word_asm;
  logic [15:0]              half_sel;
  logic [7:0]               byte_sel;
  logic [`LSU_DATA_W-1:0]   rdata_ext;

  // attributes stay with the access until the next one is granted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      type_q     <= lsu_pkg::WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      offset_q   <= '0;
    end else if (first_gnt_i) begin
      type_q     <= type_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= we_i;
      offset_q   <= offset_i;
    end
  end

  ////////////////////
  // alignment
  ////////////////////

  assign joined = {data_rdata_i, rdata_q} >> {offset_q, 3'b000};

  // aligned word comes straight, otherwise low bytes of current above high bytes of saved
  assign word_asm = (offset_q == '0) ? data_rdata_i : joined[`LSU_DATA_W-1:0];

  // offset 3 pulls lane 0 of the second word in, lower offsets read the current word only
  assign half_sel = (offset_q == '1) ? joined[15:0] : 16'(data_rdata_i >> {offset_q, 3'b000});
  assign byte_sel = data_rdata_i[{offset_q, 3'b000} +: 8];

  always_comb begin
    unique case (type_q)
      lsu_pkg::WORD: rdata_ext = word_asm;
      lsu_pkg::HALF: rdata_ext = {{(`LSU_DATA_W-16){sign_ext_q & half_sel[15]}}, half_sel};
      default:       rdata_ext = {{(`LSU_DATA_W-8){sign_ext_q & byte_sel[7]}}, byte_sel};
    endcase
  end

  // load register keeps the raw word for the first part of a split
  always_ff @(posedge clk_i) begin
    if (data_rvalid_i && !we_q) begin
      if (split_i && !second_part_i) rdata_q <= data_rdata_i;
      else                           rdata_q <= rdata_ext;
    end
  end

  assign rdata_o = data_rvalid_i ? rdata_ext : rdata_q;

  // error direction comes from the access that owns this rvalid
  assign load_err_o  = data_rvalid_i & data_err_i & ~we_q;
  assign store_err_o = data_rvalid_i & data_err_i &  we_q;

endmodule

//--- lsu_top.sv
// load store unit top, connects the execute stage to a request/grant/rvalid data memory

`include "lsu_params.svh"

module lsu_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // execute stage
  input  logic                   req_i,
  input  logic                   we_i,
  input  lsu_pkg::data_type_e    type_i,
  input  logic                   sign_ext_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   valid_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o,
  // data memory
  output logic                   data_req_o,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i
);

  logic misaligned;   // first part of a split pending
  logic split_q;      // split access open
  logic second_part;  // second part on the bus
  logic first_gnt;    // access granted

  assign data_we_o = we_i;  // requester holds we_i for the whole access

  lsu_req_gen u_req_gen (
    .req_i        (req_i),
    .type_i       (type_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .second_part_i(second_part),
    .misaligned_o (misaligned),
    .addr_o       (data_addr_o),
    .be_o         (data_be_o),
    .wdata_o      (data_wdata_o)
  );

  lsu_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .misaligned_i (misaligned),
    .data_gnt_i   (data_gnt_i),
    .data_rvalid_i(data_rvalid_i),
    .data_req_o   (data_req_o),
    .split_o      (split_q),
    .second_part_o(second_part),
    .first_gnt_o  (first_gnt),
    .valid_o      (valid_o),
    .busy_o       (busy_o)
  );

  lsu_load_align u_load_align (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .first_gnt_i  (first_gnt),
    .we_i         (we_i),
    .type_i       (type_i),
    .sign_ext_i   (sign_ext_i),
    .offset_i     (addr_i[`LSU_OFF_W-1:0]),
    .split_i      (split_q),
    .second_part_i(second_part),
    .data_rvalid_i(data_rvalid_i),
    .data_err_i   (data_err_i),
    .data_rdata_i (data_rdata_i),
    .rdata_o      (rdata_o),
    .load_err_o   (load_err_o),
    .store_err_o  (store_err_o)
  );

endmodule

//--- tb_lsu_props.sv
// protocol assertions for lsu_top, attached to every lsu_top instance through the bind below

`include "lsu_params.svh"

module tb_lsu_props (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_i,
  input logic                   data_req_i,     // data_req_o of the lsu
  input logic [`LSU_DATA_W-1:0] data_addr_i,
  input logic [`LSU_BE_W-1:0]   data_be_i,
  input logic                   data_we_i,      // data_we_o of the lsu
  input logic                   data_gnt_i,
  input logic                   data_rvalid_i,
  input logic                   data_err_i,
  input logic                   valid_i,
  input logic                   busy_i,
  input logic                   load_err_i,
  input logic                   store_err_i,
  input logic                   split_i         // split access open
);

  int unsigned fail_cnt = 0;  // failed assertions so far
  int          outstanding;   // granted parts still without rvalid
  int          gnt_cnt;       // grants since the last valid
  logic        seen_req;      // first req_i after reset
  logic        gnt_we;        // direction of the last granted part

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding <= 0;
      gnt_cnt     <= 0;
      seen_req    <= 1'b0;
      gnt_we      <= 1'b0;
    end else begin
      outstanding <= outstanding + int'(data_req_i && data_gnt_i) - int'(data_rvalid_i);
      if (valid_i)                       gnt_cnt <= 0;
      else if (data_req_i && data_gnt_i) gnt_cnt <= gnt_cnt + 1;
      if (req_i) seen_req <= 1'b1;
      if (data_req_i && data_gnt_i) gnt_we <= data_we_i;
    end
  end

  ////////////////////
  // bus protocol
  ////////////////////

  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) && $stable(data_be_i))
    else begin
      fail_cnt++;
      $error("bus request dropped or changed before its grant");
    end

  rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_rvalid_i |-> outstanding > 0)
    else begin
      fail_cnt++;
      $error("rvalid arrived with no access outstanding");
    end

  // a split access takes two grants, any other access one
  grants_per_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i |-> gnt_cnt == (split_i ? 2 : 1))
    else begin
      fail_cnt++;
      $error("wrong number of grants before valid");
    end

  ////////////////////
  // status outputs
  ////////////////////

  // bus error goes to the side of the granted direction only
  err_direction: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_rvalid_i |-> (load_err_i == (data_err_i && !gnt_we)) &&
                        (store_err_i == (data_err_i && gnt_we)))
    else begin
      fail_cnt++;
      $error("error outputs do not follow the bus error and the access direction");
    end

  quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !seen_req && !req_i |-> !data_req_i && !valid_i && !busy_i)
    else begin
      fail_cnt++;
      $error("lsu active before the first request");
    end

  // busy while requesting or while a granted part waits for rvalid
  busy_level: assert property (@(posedge clk_i) disable iff (!rst_ni)
      busy_i == (data_req_i || outstanding > 0))
    else begin
      fail_cnt++;
      $error("busy does not match the bus request and the outstanding accesses");
    end

endmodule

bind lsu_top tb_lsu_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_i        (req_i),
  .data_req_i   (data_req_o),
  .data_addr_i  (data_addr_o),
  .data_be_i    (data_be_o),
  .data_we_i    (data_we_o),
  .data_gnt_i   (data_gnt_i),
  .data_rvalid_i(data_rvalid_i),
  .data_err_i   (data_err_i),
  .valid_i      (valid_o),
  .busy_i       (busy_o),
  .load_err_i   (load_err_o),
  .store_err_i  (store_err_o),
  .split_i      (split_q)
);

//--- tb_lsu.sv
// testbench for lsu_top with a byte-enabled memory model and shadow checks, run as top tb_lsu

`include "lsu_params.svh"

module tb_lsu;

  localparam int CLK_PERIOD      = 20;
  localparam int MEM_WORDS       = 256;  // 1 KiB of data memory
  localparam int N_DIRECTED      = 28;
  localparam int N_RANDOM        = 64;
  localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 40;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_i, we_i, sign_ext_i;
  lsu_pkg::data_type_e    type_i;
  logic [`LSU_DATA_W-1:0] addr_i, wdata_i, rdata_o;
  logic                   valid_o, load_err_o, store_err_o, busy_o;
  logic                   data_req_o, data_we_o, data_gnt_i, data_rvalid_i, data_err_i;
  logic [`LSU_DATA_W-1:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [`LSU_BE_W-1:0]   data_be_o;

  logic [31:0]         mem [0:MEM_WORDS-1];     // memory model storage
  logic [7:0]          shadow [0:4*MEM_WORDS-1]; // expected memory contents by byte
  int                  gnt_dly[2], rsp_dly[2];  // drawn per part by the stimulus
  logic                cur_we;
  lsu_pkg::data_type_e cur_type;
  logic [31:0]         cur_addr;
  int                  acc_gnts;                // grants of the current access
  int                  n_errors, n_checks, n_tests, n_access, errors_at_start;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  lsu_top UUT (.*);

  ////////////////////
  // reference rules
  ////////////////////

  function automatic logic [31:0] fill_word(input int w);
    return (32'(w) * 32'h0100_0193) ^ 32'h5a3c_96e1;  // differs in every word
  endfunction

  function automatic int size_bytes(input lsu_pkg::data_type_e t);
    case (t)
      lsu_pkg::WORD: return 4;
      lsu_pkg::HALF: return 2;
      default:       return 1;
    endcase
  endfunction

  function automatic lsu_pkg::data_type_e pick_type(input int unsigned k);
    case (k)
      0:       return lsu_pkg::WORD;
      1:       return lsu_pkg::HALF;
      default: return lsu_pkg::BYTE;
    endcase
  endfunction

  function automatic logic in_err_range(input logic [31:0] a);
    return (a >= 32'h3e0) && (a < 32'h400);  // top 32 bytes answer with an error
  endfunction

  // little endian read of the shadow, then zero or sign extension
  function automatic logic [31:0] expected_load(input lsu_pkg::data_type_e t, input logic sext,
                                                input logic [31:0] a);
    int          n;
    logic [31:0] val;
    logic [9:0]  bidx;
    n   = size_bytes(t);
    val = '0;
    for (int i = 0; i < n; i++) begin
      bidx           = 10'(a + 32'(i));
      val[8*i +: 8]  = shadow[bidx];
    end
    if (sext && n < 4 && val[8*n-1]) begin
      for (int i = 8 * n; i < 32; i++) val[i] = 1'b1;
    end
    return val;
  endfunction

  // lanes from the offset up for part 0, the leftover low lanes for part 1
  function automatic logic [3:0] expected_be(input lsu_pkg::data_type_e t,
                                             input logic [1:0] off, input int part);
    int         o;
    int         n;
    logic [3:0] be;
    o  = int'(off);
    n  = size_bytes(t);
    be = '0;
    for (int lane = 0; lane < 4; lane++) begin
      if (part == 0 && lane >= o && lane < o + n) be[lane] = 1'b1;
      if (part == 1 && lane < o + n - 4)          be[lane] = 1'b1;
    end
    return be;
  endfunction

  function automatic int total_errors();
    return n_errors + int'(UUT.u_props.fail_cnt);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      n_errors++;
    end
  endtask

  ////////////////////
  // memory model
  ////////////////////

  // decides at negedge what the bus shows in the next cycle
  initial begin : memory_model
    logic       accept, gnt_nx, rvalid_nx, rsp_pend, rsp_err;
    int         wait_cnt, rsp_wait, part;
    logic [7:0] widx, rsp_widx;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i = 1'b0;
    data_rdata_i = '0;
    for (int w = 0; w < MEM_WORDS; w++) mem[8'(w)] = fill_word(w);
    rsp_pend = 1'b0;
    rsp_err  = 1'b0;
    rsp_wait = 0;
    rsp_widx = '0;
    wait_cnt = 0;
    forever begin
      @(negedge clk_i);
      accept = data_req_o && data_gnt_i;
      gnt_nx = 1'b0;
      part   = (acc_gnts > 1) ? 1 : acc_gnts;
      if (accept) begin
        check_value("data_addr_o", (part == 0) ? cur_addr : cur_addr + 32'd4, data_addr_o);
        check_value("data_we_o", 32'(cur_we), 32'(data_we_o));
        widx    = data_addr_o[9:2];
        rsp_err = in_err_range(data_addr_o);
        if (cur_we) begin
          check_value("data_be_o", 32'(expected_be(cur_type, cur_addr[1:0], part)),
                      32'(data_be_o));
          for (int b = 0; b < `LSU_BE_W; b++) begin
            if (data_be_o[b] && !rsp_err) mem[widx][8*b +: 8] = data_wdata_o[8*b +: 8];
          end
        end
        rsp_widx = widx;
        rsp_wait = rsp_dly[part];
        rsp_pend = 1'b1;
        acc_gnts++;
        wait_cnt = 0;
      end else if (data_req_o) begin
        if (wait_cnt >= gnt_dly[part]) gnt_nx = 1'b1;  // stall is over
        else wait_cnt++;
      end else begin
        wait_cnt = 0;
      end
      rvalid_nx = 1'b0;
      if (rsp_pend) begin
        if (rsp_wait == 0) begin
          rvalid_nx = 1'b1;
          rsp_pend  = 1'b0;
        end else rsp_wait--;
      end
      @(posedge clk_i);
      #2;
      data_gnt_i    = gnt_nx;
      data_rvalid_i = rvalid_nx;
      data_err_i    = rvalid_nx && rsp_err;
      data_rdata_i  = rvalid_nx ? mem[rsp_widx] : '0;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // one access from execute held until valid_o
  task automatic run_access(input logic we, input lsu_pkg::data_type_e t, input logic sext,
                            input logic [31:0] addr, input logic [31:0] wdata);
    logic        exp_err;
    logic [31:0] exp_val;
    exp_err = in_err_range(addr);
    exp_val = expected_load(t, sext, addr);
    for (int p = 0; p < 2; p++) begin
      gnt_dly[p] = $urandom % 4;
      rsp_dly[p] = $urandom % 3;  // rvalid 1 to 3 cycles after grant
    end
    @(posedge clk_i);
    #2;
    cur_we = we;
    cur_type = t;
    cur_addr = addr;
    acc_gnts = 0;
    req_i = 1'b1;
    we_i = we;
    type_i = t;
    sign_ext_i = sext;
    addr_i = addr;
    wdata_i = wdata;
    do begin
      @(negedge clk_i);
      if (data_rvalid_i) begin
        check_value("load_err_o", 32'(exp_err && !we), 32'(load_err_o));
        check_value("store_err_o", 32'(exp_err && we), 32'(store_err_o));
      end
    end while (!valid_o);
    if (!we && !exp_err) check_value("rdata_o", exp_val, rdata_o);
    if (we && !exp_err) begin
      for (int i = 0; i < size_bytes(t); i++) shadow[10'(addr + 32'(i))] = wdata[8*i +: 8];
    end
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    n_access++;
  endtask

  task automatic end_test(input string name);
    $display("test %s done with %0d errors", name, total_errors() - errors_at_start);
    errors_at_start = total_errors();
    n_tests++;
  endtask

  task automatic aligned_accesses();
    run_access(1'b1, lsu_pkg::WORD, 1'b0, 32'h100, 32'h8765_4321);
    run_access(1'b0, lsu_pkg::WORD, 1'b0, 32'h100, '0);
    run_access(1'b1, lsu_pkg::HALF, 1'b0, 32'h104, 32'h0000_8abc);
    run_access(1'b1, lsu_pkg::HALF, 1'b0, 32'h106, 32'h0000_1234);
    run_access(1'b0, lsu_pkg::HALF, 1'b0, 32'h104, '0);
    run_access(1'b0, lsu_pkg::HALF, 1'b1, 32'h104, '0);  // sign bit set
    run_access(1'b0, lsu_pkg::HALF, 1'b1, 32'h106, '0);
    for (int i = 0; i < 4; i++) run_access(1'b1, lsu_pkg::BYTE, 1'b0, 32'h108 + 32'(i),
                                           32'h7f + 32'(i));
    for (int i = 0; i < 4; i++) run_access(1'b0, lsu_pkg::BYTE, i[0], 32'h108 + 32'(i), '0);
    end_test("aligned");
  endtask

  task automatic misaligned_accesses();
    for (int i = 1; i < 4; i++) begin
      run_access(1'b1, lsu_pkg::WORD, 1'b0, 32'h200 + 32'(5 * i), 32'hc3a5_e100 + 32'(i));
      run_access(1'b0, lsu_pkg::WORD, 1'b0, 32'h200 + 32'(5 * i), '0);
    end
    run_access(1'b1, lsu_pkg::HALF, 1'b0, 32'h213, 32'h0000_f00d);
    run_access(1'b0, lsu_pkg::HALF, 1'b1, 32'h213, '0);
    run_access(1'b0, lsu_pkg::HALF, 1'b0, 32'h213, '0);
    run_access(1'b0, lsu_pkg::WORD, 1'b0, 32'h2fd, '0);  // joins two fill words
    end_test("misaligned");
  endtask

  task automatic error_accesses();
    run_access(1'b0, lsu_pkg::WORD, 1'b0, 32'h3f0, '0);
    run_access(1'b1, lsu_pkg::WORD, 1'b0, 32'h3f4, 32'h1357_9bdf);
    run_access(1'b0, lsu_pkg::BYTE, 1'b1, 32'h3e1, '0);
    end_test("bus_error");
  endtask

  task automatic random_accesses();
    logic                we;
    logic                sext;
    logic [31:0]         addr;
    lsu_pkg::data_type_e t;
    for (int k = 0; k < N_RANDOM; k++) begin
      we   = ($urandom % 2) == 1;
      sext = ($urandom % 2) == 1;
      t    = pick_type($urandom % 3);
      addr = $urandom % 32'h3c0;  // stays below the error range
      run_access(we, t, sext, addr, $urandom);
    end
    end_test("random");
  endtask

  initial begin : stimulus
    logic [31:0] word;
    void'($urandom(12845));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    type_i = lsu_pkg::WORD;
    sign_ext_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    n_errors = 0;
    n_checks = 0;
    n_tests = 0;
    n_access = 0;
    errors_at_start = 0;
    acc_gnts = 0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      word = fill_word(w);
      for (int b = 0; b < 4; b++) shadow[10'(4 * w + b)] = word[8*b +: 8];
    end
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    aligned_accesses();
    misaligned_accesses();
    error_accesses();
    random_accesses();
    repeat (2) @(posedge clk_i);  // let the last assertions fire
    $display("tests %0d, accesses %0d, checks %0d, errors %0d",
             n_tests, n_access, n_checks, total_errors());
    if (total_errors() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the accesses did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
lsu_pkg.sv
lsu_req_gen.sv
lsu_fsm.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu_props.sv
tb_lsu.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_lsu
FILELIST  = tb.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
